// File: Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
TOP        = kitchen_action_tb
FILELIST   = kitchen_action.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/facing_cell.sv
`timescale 1ns/100ps

module facing_cell import kitchen_pkg::*, player_pkg::*; (
    input  logic    vsync,
    input  logic    reset,
    input  pixel_t  player_x,
    input  pixel_t  player_y,
    input  dir_t    player_direction,
    output grid_x_t tile_x,
    output grid_y_t tile_y,
    output grid_x_t front_x,
    output grid_y_t front_y,
    output logic    front_valid
);

    logic [9:0] centre_x;
    logic [9:0] centre_y;
    logic [4:0] cur_x;
    logic [4:0] cur_y;
    logic [4:0] next_x;
    logic [4:0] next_y;

    always_comb begin
        centre_x = {1'b0, player_x} + 10'(SPRITE_HALF);
        centre_y = {1'b0, player_y} + 10'(SPRITE_HALF);
        cur_x    = centre_x[TILE_BITS +: 5];
        cur_y    = centre_y[TILE_BITS +: 5];
        next_x   = cur_x;
        next_y   = cur_y;
        case (player_direction)
            LEFT:  next_x = cur_x - 5'd1;   // 0 wraps to 31, off board
            RIGHT: next_x = cur_x + 5'd1;
            UP:    next_y = cur_y - 5'd1;
            DOWN:  next_y = cur_y + 5'd1;
        endcase
    end

    always_ff @(posedge vsync) begin
        if (reset) begin
            tile_x      <= '0;
            tile_y      <= '0;
            front_x     <= '0;
            front_y     <= '0;
            front_valid <= 1'b0;
        end else begin
            tile_x      <= grid_x_t'(cur_x);
            tile_y      <= grid_y_t'(cur_y);
            front_x     <= grid_x_t'(next_x);
            front_y     <= grid_y_t'(next_y);
            front_valid <= (cur_x < GRID_W) && (cur_y < GRID_H) &&
                           (next_x < GRID_W) && (next_y < GRID_H);
        end
    end

endmodule

// File: hw/frame_timer.sv
`timescale 1ns/100ps

module frame_timer import kitchen_pkg::*; #(
    parameter int GIVEN_FRAMES = 4
) (
    input  logic               vsync,
    input  logic               reset,
    input  logic               timer_go,
    input  logic               restart,
    output logic [TIMER_W-1:0] time_left
);

    always_ff @(posedge vsync) begin
        if (reset || restart) begin
            time_left <= TIMER_W'(GIVEN_FRAMES);
        end else if (timer_go && (time_left != '0)) begin
            time_left <= time_left - 1'b1;   // sticks at zero
        end
    end

endmodule

// File: hw/grid_if.sv
`timescale 1ns/100ps

interface grid_if import kitchen_pkg::*; ();

    grid_x_t   rd_x;
    grid_y_t   rd_y;
    grid_obj_t rd_obj;   // combinational from the board

    logic      wr_en;    // one frame strobe
    grid_x_t   wr_x;
    grid_y_t   wr_y;
    grid_obj_t wr_obj;

    modport owner (input rd_x, rd_y, wr_en, wr_x, wr_y, wr_obj,
                   output rd_obj);

    modport user (output rd_x, rd_y, wr_en, wr_x, wr_y, wr_obj,
                  input rd_obj);

endinterface

// File: hw/hand_control.sv
`timescale 1ns/100ps

module hand_control import kitchen_pkg::*, player_pkg::*; (
    input  logic    vsync,
    input  logic    reset,
    input  logic    chop,
    input  logic    carry,
    input  dir_t    player_direction,
    input  grid_x_t tile_x,
    input  grid_y_t tile_y,
    input  grid_x_t front_x,
    input  grid_y_t front_y,
    input  logic    front_valid,
    grid_if.user    gp,
    output hand_t   hand
);

    logic               chop_q;
    logic               carry_q;
    dir_t               dir_q;
    hand_t              hand_next;
    grid_obj_t          front;
    logic [1:0]         chop_go;
    logic [TIMER_W-1:0] chop_left [2];
    logic               chop_done;
    logic               at_fixture;

    function automatic hand_t held_of(grid_obj_t obj);
        case (obj)
            G_ONION_WHOLE:   return P_ONION_WHOLE;
            G_ONION_CHOPPED: return P_ONION_CHOPPED;
            G_POT_EMPTY:     return P_POT_EMPTY;
            G_POT_RAW:       return P_POT_RAW;
            G_POT_COOKED:    return P_POT_COOKED;
            G_BOWL_EMPTY:    return P_BOWL_EMPTY;
            G_BOWL_FULL:     return P_BOWL_FULL;
            G_EXTINGUISHER:  return P_EXT_OFF;
            default:         return P_NOTHING;   // fire cannot be carried
        endcase
    endfunction

    function automatic grid_obj_t drop_of(hand_t h);
        case (h)
            P_ONION_WHOLE:   return G_ONION_WHOLE;
            P_ONION_CHOPPED: return G_ONION_CHOPPED;
            P_POT_EMPTY:     return G_POT_EMPTY;
            P_POT_RAW:       return G_POT_RAW;
            P_POT_COOKED:    return G_POT_COOKED;
            P_BOWL_EMPTY:    return G_BOWL_EMPTY;
            P_BOWL_FULL:     return G_BOWL_FULL;
            P_EXT_OFF:       return G_EXTINGUISHER;
            default:         return G_EMPTY;
        endcase
    endfunction

    // buttons delayed one frame to line up with the registered front cell
    always_ff @(posedge vsync) begin
        if (reset) begin
            chop_q  <= 1'b0;
            carry_q <= 1'b0;
            dir_q   <= LEFT;
            hand    <= P_NOTHING;
        end else begin
            chop_q  <= chop;
            carry_q <= carry;
            dir_q   <= player_direction;
            hand    <= hand_next;
        end
    end

    assign front    = gp.rd_obj;
    assign gp.rd_x  = front_x;
    assign gp.rd_y  = front_y;
    assign gp.wr_x  = front_x;
    assign gp.wr_y  = front_y;

    // one timer per board, runs only while chopping above it
    for (genvar b = 0; b < 2; b++) begin : g_board
        assign chop_go[b] = (hand == P_CHOPPING) && chop_q && (dir_q == DOWN) &&
                            (tile_y == BOARD_Y - 3'd1) && (tile_x == BOARD_X[b]) &&
                            (front == G_ONION_WHOLE);

        frame_timer #(.GIVEN_FRAMES(CHOP_FRAMES)) chop_timer (
            .vsync     (vsync),
            .reset     (reset),
            .timer_go  (chop_go[b]),
            .restart   (!chop_go[b]),
            .time_left (chop_left[b])
        );
    end

    assign chop_done  = (chop_go[0] && (chop_left[0] == '0)) ||
                        (chop_go[1] && (chop_left[1] == '0));
    assign at_fixture = ((front_x == BIN_X) && ((front_y == BIN0_Y) || (front_y == BIN1_Y))) ||
                        ((front_x == BOWL_X) && (front_y == BOWL_Y));

    always_comb begin
        hand_next = hand;
        gp.wr_en  = 1'b0;
        gp.wr_obj = G_EMPTY;
        case (hand)
            P_NOTHING: begin
                if (chop_q) begin
                    hand_next = P_CHOPPING;
                end else if (carry_q && front_valid && (held_of(front) != P_NOTHING)) begin
                    hand_next = held_of(front);
                    gp.wr_en  = !at_fixture;   // bins and stack never run out
                end
            end
            P_CHOPPING: begin
                if (!chop_q) begin
                    hand_next = P_NOTHING;
                end else if (chop_done) begin
                    gp.wr_en  = 1'b1;
                    gp.wr_obj = G_ONION_CHOPPED;
                end
            end
            P_EXT_ON: begin
                if (!chop_q) begin
                    hand_next = P_EXT_OFF;
                end else if (front_valid && (front == G_FIRE)) begin
                    gp.wr_en = 1'b1;   // spray clears the fire
                end
            end
            default: begin
                if ((hand == P_EXT_OFF) && chop_q) begin
                    hand_next = P_EXT_ON;
                end else if (!carry_q && front_valid) begin
                    if (front == G_EMPTY) begin
                        hand_next = P_NOTHING;
                        gp.wr_en  = 1'b1;
                        gp.wr_obj = drop_of(hand);
                    end else if (((hand == P_ONION_CHOPPED) && (front == G_POT_EMPTY)) ||
                                 ((hand == P_POT_EMPTY) && (front == G_ONION_CHOPPED))) begin
                        hand_next = P_NOTHING;
                        gp.wr_en  = 1'b1;
                        gp.wr_obj = G_POT_RAW;
                    end else if ((hand == P_POT_COOKED) && (front == G_BOWL_EMPTY)) begin
                        hand_next = P_POT_EMPTY;   // pour, keep the pot
                        gp.wr_en  = 1'b1;
                        gp.wr_obj = G_BOWL_FULL;
                    end
                end
            end
        endcase
    end

endmodule

// File: hw/kitchen_action.sv
`timescale 1ns/100ps

module kitchen_action import kitchen_pkg::*, player_pkg::*; (
    input  logic               vsync,
    input  logic               reset,
    input  logic               chop,
    input  logic               carry,
    input  pixel_t             player_x,
    input  pixel_t             player_y,
    input  dir_t               player_direction,
    output object_grid_t       object_grid,
    output hand_t              hand,
    output logic [TIMER_W-1:0] stove_left
);

    grid_x_t   tile_x;
    grid_y_t   tile_y;
    grid_x_t   front_x;
    grid_y_t   front_y;
    logic      front_valid;
    logic      stove_wr;
    grid_obj_t stove_obj;
    grid_obj_t burner_obj;

    grid_if gp ();

    facing_cell facing_cell_i (
        .vsync            (vsync),
        .reset            (reset),
        .player_x         (player_x),
        .player_y         (player_y),
        .player_direction (player_direction),
        .tile_x           (tile_x),
        .tile_y           (tile_y),
        .front_x          (front_x),
        .front_y          (front_y),
        .front_valid      (front_valid)
    );

    kitchen_grid kitchen_grid_i (
        .vsync       (vsync),
        .reset       (reset),
        .gp          (gp.owner),
        .stove_wr    (stove_wr),
        .stove_obj   (stove_obj),
        .burner_obj  (burner_obj),
        .object_grid (object_grid)
    );

    hand_control hand_control_i (
        .vsync            (vsync),
        .reset            (reset),
        .chop             (chop),
        .carry            (carry),
        .player_direction (player_direction),
        .tile_x           (tile_x),
        .tile_y           (tile_y),
        .front_x          (front_x),
        .front_y          (front_y),
        .front_valid      (front_valid),
        .gp               (gp.user),
        .hand             (hand)
    );

    stove_control stove_control_i (
        .vsync      (vsync),
        .reset      (reset),
        .burner_obj (burner_obj),
        .stove_wr   (stove_wr),
        .stove_obj  (stove_obj),
        .stove_left (stove_left)
    );

endmodule

// File: hw/kitchen_grid.sv
`timescale 1ns/100ps

module kitchen_grid import kitchen_pkg::*; (
    input  logic         vsync,
    input  logic         reset,
    grid_if.owner        gp,
    input  logic         stove_wr,
    input  grid_obj_t    stove_obj,
    output grid_obj_t    burner_obj,
    output object_grid_t object_grid
);

    always_ff @(posedge vsync) begin
        if (reset) begin
            // fixture layout
            object_grid <= '0;
            object_grid[BIN0_Y][BIN_X]      <= G_ONION_WHOLE;
            object_grid[BIN1_Y][BIN_X]      <= G_ONION_WHOLE;
            object_grid[BOWL_Y][BOWL_X]     <= G_BOWL_EMPTY;
            object_grid[BURNER_Y][BURNER_X] <= G_POT_EMPTY;
            object_grid[BURNER_Y][EXT_X]    <= G_EXTINGUISHER;
            for (int i = SPARE_X_FIRST; i <= SPARE_X_LAST; i++) begin
                object_grid[BURNER_Y][i] <= G_POT_EMPTY;
            end
        end else begin
            if (gp.wr_en) begin
                object_grid[gp.wr_y][gp.wr_x] <= gp.wr_obj;
            end
            if (stove_wr) begin
                object_grid[BURNER_Y][BURNER_X] <= stove_obj;   // last write wins
            end
        end
    end

    // columns past the board read as empty
    assign gp.rd_obj = (gp.rd_x < GRID_W) ? grid_obj_t'(object_grid[gp.rd_y][gp.rd_x])
                                          : G_EMPTY;

    assign burner_obj = grid_obj_t'(object_grid[BURNER_Y][BURNER_X]);

endmodule

// File: hw/kitchen_pkg.sv
package kitchen_pkg;

    localparam int GRID_W = 13;
    localparam int GRID_H = 8;

    typedef logic [3:0] grid_x_t;
    typedef logic [2:0] grid_y_t;

    typedef enum logic [3:0] {
        G_EMPTY         = 4'd0,
        G_ONION_WHOLE   = 4'd1,
        G_ONION_CHOPPED = 4'd2,
        G_BOWL_EMPTY    = 4'd3,
        G_BOWL_FULL     = 4'd4,
        G_POT_EMPTY     = 4'd5,
        G_POT_RAW       = 4'd6,
        G_POT_COOKED    = 4'd7,
        G_FIRE          = 4'd9,
        G_EXTINGUISHER  = 4'd10
    } grid_obj_t;

    // row major, 4 bits per cell
    typedef logic [GRID_H-1:0][GRID_W-1:0][3:0] object_grid_t;

    localparam grid_x_t BIN_X  = 4'd0;   // two bins, same column
    localparam grid_y_t BIN0_Y = 3'd2;
    localparam grid_y_t BIN1_Y = 3'd3;
    localparam grid_x_t BOWL_X = 4'd12;
    localparam grid_y_t BOWL_Y = 3'd6;
    localparam grid_y_t BOARD_Y = 3'd7;
    localparam grid_x_t BOARD_X [2] = '{4'd2, 4'd4};

    // spares and extinguisher share the burner row
    localparam grid_y_t BURNER_Y      = 3'd0;
    localparam grid_x_t BURNER_X      = 4'd8;
    localparam grid_x_t SPARE_X_FIRST = 4'd9;
    localparam grid_x_t SPARE_X_LAST  = 4'd11;
    localparam grid_x_t EXT_X         = 4'd7;

    localparam int TIMER_W     = 4;
    localparam int CHOP_FRAMES = 4;   // short counts for simulation
    localparam int COOK_FRAMES = 6;
    localparam int BURN_FRAMES = 6;

endpackage

// File: hw/player_pkg.sv
package player_pkg;

    typedef enum logic [1:0] {
        LEFT  = 2'd0,
        RIGHT = 2'd1,
        UP    = 2'd2,
        DOWN  = 2'd3
    } dir_t;

    typedef enum logic [3:0] {
        P_NOTHING       = 4'd0,
        P_CHOPPING      = 4'd1,
        P_ONION_WHOLE   = 4'd2,
        P_ONION_CHOPPED = 4'd3,
        P_POT_EMPTY     = 4'd4,
        P_POT_RAW       = 4'd5,
        P_POT_COOKED    = 4'd6,
        P_BOWL_EMPTY    = 4'd7,
        P_BOWL_FULL     = 4'd8,
        P_EXT_OFF       = 4'd9,
        P_EXT_ON        = 4'd10
    } hand_t;

    typedef logic [8:0] pixel_t;

    localparam int SPRITE_HALF = 16;
    localparam int TILE_BITS   = 5;   // 32 pixel tiles

endpackage

// File: hw/stove_control.sv
`timescale 1ns/100ps

module stove_control import kitchen_pkg::*; (
    input  logic               vsync,
    input  logic               reset,
    input  grid_obj_t          burner_obj,
    output logic               stove_wr,
    output grid_obj_t          stove_obj,
    output logic [TIMER_W-1:0] stove_left
);

    typedef enum logic [1:0] {
        S_NONE,
        S_RAW,
        S_COOKED,
        S_FIRE
    } stove_state_t;

    stove_state_t       state;
    logic               cook_go;
    logic               burn_go;
    logic [TIMER_W-1:0] cook_left;
    logic [TIMER_W-1:0] burn_left;

    assign cook_go = (state == S_RAW);
    assign burn_go = (state == S_COOKED);

    frame_timer #(.GIVEN_FRAMES(COOK_FRAMES)) cook_timer (
        .vsync     (vsync),
        .reset     (reset),
        .timer_go  (cook_go),
        .restart   (!cook_go),
        .time_left (cook_left)
    );

    frame_timer #(.GIVEN_FRAMES(BURN_FRAMES)) burn_timer (
        .vsync     (vsync),
        .reset     (reset),
        .timer_go  (burn_go),
        .restart   (!burn_go),
        .time_left (burn_left)
    );

    always_ff @(posedge vsync) begin
        if (reset) begin
            state <= S_NONE;
        end else begin
            case (state)
                S_NONE: if (burner_obj == G_POT_RAW) state <= S_RAW;
                S_RAW: begin
                    if (burner_obj != G_POT_RAW) state <= S_NONE;   // pot lifted
                    else if (cook_left == '0) state <= S_COOKED;
                end
                S_COOKED: begin
                    if (burner_obj != G_POT_COOKED) state <= S_NONE;
                    else if (burn_left == '0) state <= S_FIRE;
                end
                S_FIRE: if (burner_obj != G_FIRE) state <= S_NONE;   // put out
            endcase
        end
    end

    // write lands with the state change
    assign stove_wr = (cook_go && (burner_obj == G_POT_RAW) && (cook_left == '0)) ||
                      (burn_go && (burner_obj == G_POT_COOKED) && (burn_left == '0));
    assign stove_obj  = cook_go ? G_POT_COOKED : G_FIRE;
    assign stove_left = cook_go ? cook_left : (burn_go ? burn_left : '0);

endmodule

// File: kitchen_action.f
hw/kitchen_pkg.sv
hw/player_pkg.sv
hw/grid_if.sv
hw/frame_timer.sv
hw/facing_cell.sv
hw/kitchen_grid.sv
hw/hand_control.sv
hw/stove_control.sv
hw/kitchen_action.sv
test/kitchen_action_tb.sv

// File: test/kitchen_action_tb.sv
`timescale 1ns/100ps

module kitchen_action_tb import kitchen_pkg::*, player_pkg::*; ();

    logic               vsync;
    logic               reset;
    logic               chop;
    logic               carry;
    pixel_t             player_x;
    pixel_t             player_y;
    dir_t               player_direction;
    object_grid_t       object_grid;
    hand_t              hand;
    logic [TIMER_W-1:0] stove_left;

    integer seed;
    int     errors;
    int     checks;
    int     tests_run;
    int     tests_failed;
    int     cur_test;
    int     steps_in_test;
    int     errors_at_start;

    // occupied fixtures for the random drop test, with the tile in front of each
    int spot_px  [4] = '{32, 32, 352, 352};
    int spot_py  [4] = '{64, 96, 192, 32};
    int spot_dir [4] = '{0, 0, 1, 2};
    int spot_row [4] = '{2, 3, 6, 0};
    int spot_col [4] = '{0, 0, 12, 11};
    int spot_obj [4] = '{1, 1, 3, 5};

    kitchen_action kitchen_action_i (
        .vsync            (vsync),
        .reset            (reset),
        .chop             (chop),
        .carry            (carry),
        .player_x         (player_x),
        .player_y         (player_y),
        .player_direction (player_direction),
        .object_grid      (object_grid),
        .hand             (hand),
        .stove_left       (stove_left)
    );

    always #4 vsync = ~vsync;

    function automatic logic [3:0] cell_at(int r, int c);
        return object_grid[r[2:0]][c[3:0]];
    endfunction

    // board contents right after reset
    function automatic logic [3:0] reset_object(int r, int c);
        if ((c == 0) && ((r == 2) || (r == 3))) return 4'd1;   // onion bins
        if ((r == 6) && (c == 12)) return 4'd3;                 // bowl stack
        if ((r == 0) && (c == 7)) return 4'd10;
        if ((r == 0) && (c >= 8) && (c <= 11)) return 4'd5;     // burner starts with a pot
        return 4'd0;
    endfunction

    task automatic next_frame;
        @(posedge vsync);
        @(negedge vsync);
    endtask

    task automatic drive_inputs(int px, int py, int d, int ca, int ch);
        player_x         = pixel_t'(px);
        player_y         = pixel_t'(py);
        player_direction = dir_t'(d[1:0]);
        carry            = ca[0];
        chop             = ch[0];
    endtask

    task automatic expect_cell(int r, int c, int obj);
        checks++;
        assert (cell_at(r, c) == obj[3:0]) else begin
            $display("ERR object_grid[%0d][%0d] got %h expected %h",
                     r, c, cell_at(r, c), obj[3:0]);
            errors++;
        end
    endtask

    task automatic expect_hand(int h);
        checks++;
        assert (hand == hand_t'(h[3:0])) else begin
            $display("ERR hand got %h expected %h", hand, h[3:0]);
            errors++;
        end
    endtask

    task automatic confirm_grid_kept(object_grid_t snap);
        checks++;
        assert (object_grid == snap) else begin
            $display("ERR object_grid got %h expected %h", object_grid, snap);
            errors++;
        end
    endtask

    task automatic scan_reset_layout;
        for (int r = 0; r < GRID_H; r++) begin
            for (int c = 0; c < GRID_W; c++) begin
                expect_cell(r, c, reset_object(r, c));
            end
        end
    endtask

    task automatic wait_cell(int r, int c, int obj, int limit);
        int n;
        n = 0;
        while ((cell_at(r, c) != obj[3:0]) && (n < limit)) begin
            next_frame;
            n++;
        end
        if (cell_at(r, c) != obj[3:0]) begin
            $display("timeout: cell at row %0d column %0d did not change to %0d within %0d frames",
                     r, c, obj, limit);
            errors++;
        end
    endtask

    // remaining frames start full and drop by one per frame
    task automatic wait_stove_expiry(int start, int limit);
        int                 n;
        logic [TIMER_W-1:0] prev;
        n = 0;
        checks++;
        assert (stove_left == TIMER_W'(start)) else begin
            $display("ERR stove_left got %h expected %h", stove_left, TIMER_W'(start));
            errors++;
        end
        while ((stove_left != '0) && (n < limit)) begin
            prev = stove_left;
            next_frame;
            n++;
            assert (stove_left == prev - 1'b1) else begin
                $display("ERR stove_left got %h expected %h", stove_left, prev - 1'b1);
                errors++;
            end
        end
        if (stove_left != '0) begin
            $display("timeout: stove timer did not run out within %0d frames", limit);
            errors++;
        end
    endtask

    task automatic close_test;
        int errs;
        errs = errors - errors_at_start;
        tests_run++;
        if (errs != 0) tests_failed++;
        $display("test %0d: %0d steps, %0d errors, %s",
                 cur_test, steps_in_test, errs, (errs == 0) ? "ok" : "FAIL");
    endtask

    task automatic play_stim_file;
        int           fd;
        int           code;
        int           records;
        string        line;
        int           t, mode, px, py, d, ca, ch, hold, r, c, obj, h;
        int           idx;
        object_grid_t snap;
        records = 0;
        fd = $fopen("test/kitchen_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file test/kitchen_stim.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code == 0) break;
            if ((line.len() < 2) || (line.getc(0) == "#")) continue;
            code = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d",
                           t, mode, px, py, d, ca, ch, hold, r, c, obj, h);
            if (code != 12) begin
                $display("stimulus line could not be read: %s", line);
                errors++;
                continue;
            end
            records++;
            if (t != cur_test) begin
                if (cur_test != 0) close_test;
                cur_test        = t;
                steps_in_test   = 0;
                errors_at_start = errors;
            end
            if (mode == 3) begin
                idx  = $unsigned($random(seed)) % 4;
                px   = spot_px[idx];
                py   = spot_py[idx];
                d    = spot_dir[idx];
                r    = spot_row[idx];
                c    = spot_col[idx];
                obj  = spot_obj[idx];
                snap = object_grid;
            end
            drive_inputs(px, py, d, ca, ch);
            case (mode)
                1: wait_cell(r, c, obj, hold);
                2: begin
                    // cooked pot ends the cook stage, fire ends the burn stage
                    wait_stove_expiry((obj == 7) ? COOK_FRAMES : BURN_FRAMES, hold);
                    wait_cell(r, c, obj, 3);   // write lands one frame after expiry
                end
                default: repeat (hold) next_frame;
            endcase
            expect_cell(r, c, obj);
            expect_hand(h);
            if (mode == 3) confirm_grid_kept(snap);
            steps_in_test++;
        end
        $fclose(fd);
        if (cur_test != 0) close_test;
        if (records == 0) begin
            $display("the stimulus file held no steps");
            errors++;
        end
    endtask

    initial begin
        seed             = 3;
        errors           = 0;
        checks           = 0;
        tests_run        = 0;
        tests_failed     = 0;
        vsync            = 1'b0;
        reset            = 1'b1;
        chop             = 1'b0;
        carry            = 1'b0;
        player_x         = pixel_t'(192);
        player_y         = pixel_t'(128);
        player_direction = RIGHT;
        repeat (2) @(posedge vsync);
        @(negedge vsync);
        reset = 1'b0;

        cur_test        = 1;
        steps_in_test   = 1;
        errors_at_start = errors;
        scan_reset_layout;
        expect_hand(0);
        close_test;
        cur_test = 0;

        play_stim_file;

        $display("%0d tests, %0d failing, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: test/kitchen_stim.txt
# test mode x y dir carry chop frames row col object hand
# mode 0 hold then check, 1 poll the cell, 2 wait for the stove stage, 3 random fixture
# onion from a bin onto the left board
2 0 40 60 0 1 0 3 2 0 1 2
2 0 64 192 3 1 0 3 7 2 0 2
2 0 64 192 3 0 0 3 7 2 1 0
# chopping
3 1 64 192 3 0 1 7 7 2 2 1
3 0 64 192 3 0 0 3 7 2 2 0
# raw pot, cook, pour
4 0 64 192 3 1 0 3 7 2 0 3
4 0 288 32 2 1 0 3 0 9 5 3
4 0 288 32 2 0 0 3 0 9 6 0
4 0 352 192 1 1 0 3 6 12 3 7
4 0 352 192 2 0 0 3 5 11 3 0
4 0 256 32 2 1 0 3 0 8 0 4
4 0 256 32 3 0 0 3 2 8 5 0
4 0 288 32 2 1 0 3 0 9 0 5
4 0 256 32 2 1 0 3 0 8 0 5
4 0 256 32 2 0 0 3 0 8 6 0
4 2 256 32 2 0 0 9 0 8 7 0
4 0 256 32 2 1 0 3 0 8 0 6
4 0 352 128 3 1 0 3 5 11 3 6
4 0 352 128 3 0 0 3 5 11 4 4
# second pot left to burn, then the extinguisher
5 0 352 128 2 0 0 3 3 11 5 0
5 0 32 64 0 1 0 3 2 0 1 2
5 0 64 192 3 1 0 3 7 2 0 2
5 0 64 192 3 0 0 3 7 2 1 0
5 1 64 192 3 0 1 7 7 2 2 1
5 0 64 192 3 0 0 3 7 2 2 0
5 0 320 32 2 1 0 3 0 10 0 4
5 0 64 192 3 1 0 3 7 2 2 4
5 0 64 192 3 0 0 3 7 2 6 0
5 0 64 192 3 1 0 3 7 2 0 5
5 0 256 32 2 1 0 3 0 8 0 5
5 0 256 32 2 0 0 3 0 8 6 0
5 2 256 32 2 0 0 9 0 8 7 0
5 2 256 32 2 0 0 9 0 8 9 0
5 0 224 32 2 1 0 3 0 7 0 9
5 0 256 32 2 1 1 4 0 8 0 10
5 0 256 32 2 1 0 3 0 8 0 9
# drops in front of random fixtures, position and cell come from the testbench
6 3 0 0 0 0 0 3 0 0 0 9
6 3 0 0 0 0 0 3 0 0 0 9
6 3 0 0 0 0 0 3 0 0 0 9
